//--- include/optim_settings.svh
`ifndef OPTIM_SETTINGS_SVH
`define OPTIM_SETTINGS_SVH

// ------------------------------
// datapath shape
// ------------------------------

// lanes packed side by side in one memory word
`define DATA_N 4

// lane value width and its fraction part
`define N_LEN_W 16
`define F_LEN_W 8

// ------------------------------
// matrix layout
// ------------------------------

// side of a square mixing matrix
`define HID_DIM 8

// words per matrix
`define MAT_WORDS ((`HID_DIM * `HID_DIM) / `DATA_N)

// three matrices back to back
`define ADDR_W 6

// ------------------------------
// update constants, fixed point
// ------------------------------

// 0.875
`define MOMENTUM 224

// 0.0625
`define LR 16

`endif

//--- source/optim_pkg.sv
`include "optim_settings.svh"

package optim_pkg;

  // one signed fixed-point lane
  typedef logic signed [`N_LEN_W-1:0] lane_t;

  // a full memory word, lane 0 in the low bits
  typedef lane_t [`DATA_N-1:0] word_t;

  typedef logic [`ADDR_W-1:0] addr_t;

  // matrix selector, bases at 0, MAT_WORDS and 2*MAT_WORDS
  typedef enum logic [1:0] {
    MIX1 = 2'd0,
    MIX2 = 2'd1,
    MIX3 = 2'd2
  } mix_sel_e;

  // memory chosen by the host port
  typedef enum logic [1:0] {
    FIELD_W    = 2'd0,
    FIELD_V    = 2'd1,
    FIELD_GRAD = 2'd2
  } field_e;

endpackage

//--- source/optim_if.sv
// ------------------------------
// read side of the parameter memory
// ------------------------------
interface optim_rd_if;

  optim_pkg::addr_t raddr;

  // returned one cycle after raddr
  optim_pkg::word_t rdata_w;
  optim_pkg::word_t rdata_v;
  optim_pkg::word_t rdata_grad;

  modport memory (
    input  raddr,
    output rdata_w,
    output rdata_v,
    output rdata_grad
  );

  modport sequencer (
    output raddr
  );

endinterface

// ------------------------------
// write side of the parameter memory
// ------------------------------
interface optim_wr_if;

  logic             we;
  optim_pkg::addr_t waddr;
  optim_pkg::word_t wdata_w;
  optim_pkg::word_t wdata_v;

  modport memory (
    input we,
    input waddr,
    input wdata_w,
    input wdata_v
  );

  modport writer (
    output we,
    output waddr,
    output wdata_w,
    output wdata_v
  );

endinterface

//--- source/param_bank.sv
`include "optim_settings.svh"

module param_bank (
  input  logic                clk,
  optim_rd_if.memory          rd,
  optim_wr_if.memory          wr,
  input  logic                host_we,
  input  optim_pkg::field_e   host_field,
  input  optim_pkg::addr_t    host_addr,
  input  optim_pkg::word_t    host_wdata,
  output optim_pkg::word_t    host_rdata
);

  localparam int DEPTH = 3 * `MAT_WORDS;

  optim_pkg::word_t mem_w    [DEPTH];
  optim_pkg::word_t mem_v    [DEPTH];
  optim_pkg::word_t mem_grad [DEPTH];

  // memories power up cleared
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem_w[i]    = '0;
      mem_v[i]    = '0;
      mem_grad[i] = '0;
    end
  end

  // ------------------------------
  // update port and host writes
  // ------------------------------
  always @(posedge clk) begin
    rd.rdata_w    <= mem_w[rd.raddr];
    rd.rdata_v    <= mem_v[rd.raddr];
    rd.rdata_grad <= mem_grad[rd.raddr];
    if (wr.we) begin
      mem_w[wr.waddr] <= wr.wdata_w;
      mem_v[wr.waddr] <= wr.wdata_v;
    end
    if (host_we) begin
      case (host_field)
        optim_pkg::FIELD_W:    mem_w[host_addr]    <= host_wdata;
        optim_pkg::FIELD_V:    mem_v[host_addr]    <= host_wdata;
        optim_pkg::FIELD_GRAD: mem_grad[host_addr] <= host_wdata;
        default: ;
      endcase
    end
  end

  // host read, no latency
  always_comb begin
    case (host_field)
      optim_pkg::FIELD_W:    host_rdata = mem_w[host_addr];
      optim_pkg::FIELD_V:    host_rdata = mem_v[host_addr];
      optim_pkg::FIELD_GRAD: host_rdata = mem_grad[host_addr];
      default:               host_rdata = '0;
    endcase
  end

  // host may only write while no pass is draining
  a_no_write_clash: assert property (@(posedge clk) !(wr.we && host_we))
    else $error("param_bank: update write and host write in the same cycle");

endmodule

//--- source/optim_sequencer.sv
`include "optim_settings.svh"

module optim_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  optim_pkg::mix_sel_e   sel,
  optim_rd_if.sequencer         rd,
  output logic                  issue,
  output logic                  done
);

  localparam int CNT_W = $clog2(`MAT_WORDS);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`MAT_WORDS - 1);

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_d [4];
  // last word of the pass already read
  logic             spent;

  function automatic optim_pkg::addr_t mix_base(input optim_pkg::mix_sel_e s);
    case (s)
      optim_pkg::MIX2: return optim_pkg::addr_t'(`MAT_WORDS);
      optim_pkg::MIX3: return optim_pkg::addr_t'(2 * `MAT_WORDS);
      default:         return '0;
    endcase
  endfunction

  // ------------------------------
  // read address stream
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count    <= '0;
      spent    <= 1'b0;
      rd.raddr <= '0;
    end else if (run) begin
      if (count != LAST) begin
        count    <= count + 1'b1;
        rd.raddr <= rd.raddr + 1'b1;
      end else begin
        spent <= 1'b1;
      end
    end else begin
      // park on the base of the chosen matrix
      count    <= '0;
      spent    <= 1'b0;
      rd.raddr <= mix_base(sel);
    end
  end

  assign issue = run & ~spent;

  // counter delayed to line up with the last write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) count_d[i] <= '0;
    end else if (!run) begin
      for (int i = 0; i < 4; i++) count_d[i] <= '0;
    end else begin
      count_d[0] <= count;
      for (int i = 1; i < 4; i++) count_d[i] <= count_d[i-1];
    end
  end

  assign done = run & (count_d[3] == LAST);

  a_raddr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    run && $past(run) |->
      (rd.raddr >= mix_base(sel)) && (rd.raddr < mix_base(sel) + `MAT_WORDS))
    else $error("optim_sequencer: raddr %0d left the selected matrix", rd.raddr);

endmodule

//--- source/momentum_lane.sv
`include "optim_settings.svh"

module momentum_lane (
  input  logic              clk,
  input  logic              rst_n,
  input  optim_pkg::lane_t  w_in,
  input  optim_pkg::lane_t  v_in,
  input  optim_pkg::lane_t  grad_in,
  output optim_pkg::lane_t  w_out,
  output optim_pkg::lane_t  v_out
);

  optim_pkg::lane_t mul_mtm;
  optim_pkg::lane_t mul_lr;
  optim_pkg::lane_t w_d;
  optim_pkg::lane_t step;

  // signed product, keep the bits at the fraction offset
  function automatic optim_pkg::lane_t fixed_mul(input optim_pkg::lane_t a,
                                                 input optim_pkg::lane_t b);
    logic signed [2*`N_LEN_W-1:0] prod;
    prod = a * b;
    return prod[`F_LEN_W +: `N_LEN_W];
  endfunction

  // ------------------------------
  // stage 1: products
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mul_mtm <= '0;
      mul_lr  <= '0;
      w_d     <= '0;
    end else begin
      mul_mtm <= fixed_mul(optim_pkg::lane_t'(`MOMENTUM), v_in);
      mul_lr  <= fixed_mul(optim_pkg::lane_t'(`LR), grad_in);
      w_d     <= w_in;
    end
  end

  // new velocity, wraps on overflow
  assign step = mul_mtm - mul_lr;

  // ------------------------------
  // stage 2: new v and w
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v_out <= '0;
      w_out <= '0;
    end else begin
      v_out <= step;
      w_out <= w_d + step;
    end
  end

endmodule

//--- source/optim_writeback.sv
module optim_writeback (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              issue,
  input  optim_pkg::addr_t  raddr,
  input  optim_pkg::word_t  w_res,
  input  optim_pkg::word_t  v_res,
  optim_wr_if.writer        wr
);

  logic [1:0]       issue_d;
  optim_pkg::addr_t addr_d [2];

  // ------------------------------
  // address and strobe delay
  // ------------------------------
  // one cycle of memory latency plus two lane stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_d   <= '0;
      addr_d[0] <= '0;
      addr_d[1] <= '0;
      wr.we     <= 1'b0;
      wr.waddr  <= '0;
    end else begin
      issue_d   <= {issue_d[0], issue};
      addr_d[0] <= raddr;
      addr_d[1] <= addr_d[0];
      wr.we     <= issue_d[1];
      wr.waddr  <= addr_d[1];
    end
  end

  // lane results come straight off the stage 2 registers
  assign wr.wdata_w = w_res;
  assign wr.wdata_v = v_res;

  a_waddr_step: assert property (@(posedge clk) disable iff (!rst_n)
    wr.we && $past(wr.we) |-> wr.waddr == optim_pkg::addr_t'($past(wr.waddr) + 1'b1))
    else $error("optim_writeback: waddr %0d does not follow %0d",
                wr.waddr, $past(wr.waddr));

endmodule

//--- source/mix_optim_top.sv
`include "optim_settings.svh"

module mix_optim_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  optim_pkg::mix_sel_e   sel,
  input  logic                  host_we,
  input  optim_pkg::field_e     host_field,
  input  optim_pkg::addr_t      host_addr,
  input  optim_pkg::word_t      host_wdata,
  output optim_pkg::word_t      host_rdata,
  output logic                  done
);

  optim_rd_if rd_bus ();
  optim_wr_if wr_bus ();

  logic             issue;
  optim_pkg::word_t w_res;
  optim_pkg::word_t v_res;

  // ------------------------------
  // memory and address control
  // ------------------------------
  param_bank u_bank (
    .clk        (clk),
    .rd         (rd_bus),
    .wr         (wr_bus),
    .host_we    (host_we),
    .host_field (host_field),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

  optim_sequencer u_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .sel   (sel),
    .rd    (rd_bus),
    .issue (issue),
    .done  (done)
  );

  // ------------------------------
  // update lanes
  // ------------------------------
  for (genvar i = 0; i < `DATA_N; i++) begin : g_lane
    momentum_lane u_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .w_in    (rd_bus.rdata_w[i]),
      .v_in    (rd_bus.rdata_v[i]),
      .grad_in (rd_bus.rdata_grad[i]),
      .w_out   (w_res[i]),
      .v_out   (v_res[i])
    );
  end

  optim_writeback u_wb (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (issue),
    .raddr (rd_bus.raddr),
    .w_res (w_res),
    .v_res (v_res),
    .wr    (wr_bus)
  );

endmodule

//--- tb/tb_mix_optim.sv
`include "optim_settings.svh"

module tb_mix_optim;

  localparam int DEPTH        = 3 * `MAT_WORDS;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN        = 6;
  localparam int NUM_STEPS    = 6;

  typedef enum logic {PASS_FULL, PASS_CUT} pass_kind_e;

  typedef struct packed {
    optim_pkg::mix_sel_e sel;
    logic [7:0]          run_len;
    pass_kind_e          kind;
  } step_t;

  // selector, run cycles (upper bound for a full pass), kind
  step_t steps [NUM_STEPS] = '{
    '{optim_pkg::MIX1, 8'(`MAT_WORDS + 8), PASS_FULL},
    '{optim_pkg::MIX1, 8'(`MAT_WORDS + 8), PASS_FULL},
    '{optim_pkg::MIX2, 8'(`MAT_WORDS + 8), PASS_FULL},
    '{optim_pkg::MIX3, 8'(`MAT_WORDS + 8), PASS_FULL},
    '{optim_pkg::MIX3, 8'd5,               PASS_CUT},
    '{optim_pkg::MIX3, 8'(`MAT_WORDS + 8), PASS_FULL}
  };

  logic                clk;
  logic                rst_n;
  logic                run;
  optim_pkg::mix_sel_e sel;
  logic                host_we;
  optim_pkg::field_e   host_field;
  optim_pkg::addr_t    host_addr;
  optim_pkg::word_t    host_wdata;
  optim_pkg::word_t    host_rdata;
  logic                done;

  // shadow copy of the three memories
  optim_pkg::word_t ref_w [DEPTH];
  optim_pkg::word_t ref_v [DEPTH];
  optim_pkg::word_t ref_g [DEPTH];

  logic [31:0] rng_state    = 32'had23_631a;
  int          checks       = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  mix_optim_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .sel        (sel),
    .host_we    (host_we),
    .host_field (host_field),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .done       (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [`N_LEN_W-1:0] next_lane();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  // x times a fixed-point constant with the low bits dropped at the fraction point
  function automatic logic signed [`N_LEN_W-1:0] fixed_scale(
    input logic signed [`N_LEN_W-1:0] x, input int k);
    longint p;
    p = longint'(x) * k;
    return p >>> `F_LEN_W;
  endfunction

  function automatic int timeout_limit();
    int total;
    total = RESET_CYCLES + 2 * 3 * DEPTH + 2;
    foreach (steps[i]) total += 3 + int'(steps[i].run_len) + DRAIN + 3 * DEPTH;
    return total + 64;
  endfunction

  task automatic model_update(input int base, input int count);
    logic signed [`N_LEN_W-1:0] w;
    logic signed [`N_LEN_W-1:0] v;
    logic signed [`N_LEN_W-1:0] g;
    logic signed [`N_LEN_W-1:0] vn;
    for (int a = base; a < base + count; a++) begin
      for (int l = 0; l < `DATA_N; l++) begin
        w  = ref_w[a][l];
        v  = ref_v[a][l];
        g  = ref_g[a][l];
        vn = fixed_scale(v, `MOMENTUM) - fixed_scale(g, `LR);
        ref_v[a][l] = vn;
        ref_w[a][l] = w + vn;
      end
    end
  endtask

  task automatic host_write(input optim_pkg::field_e f, input int a,
                            input optim_pkg::word_t d);
    @(posedge clk);
    #10 host_we = 1'b1;
    host_field = f;
    host_addr  = optim_pkg::addr_t'(a);
    host_wdata = d;
  endtask

  task automatic load_memories();
    optim_pkg::word_t d;
    for (int a = 0; a < DEPTH; a++) begin
      for (int f = 0; f < 3; f++) begin
        for (int l = 0; l < `DATA_N; l++) d[l] = next_lane();
        host_write(optim_pkg::field_e'(f), a, d);
        if (f == 0) ref_w[a] = d;
        else if (f == 1) ref_v[a] = d;
        else ref_g[a] = d;
      end
    end
    @(posedge clk);
    #10 host_we = 1'b0;
  endtask

  task automatic check_word(input optim_pkg::field_e f, input int a,
                            input optim_pkg::word_t exp, input string name);
    @(posedge clk);
    #10 host_field = f;
    host_addr = optim_pkg::addr_t'(a);
    @(negedge clk);
    checks++;
    assert (host_rdata === exp) else begin
      value_errors++;
      $display("** Error at time %0t: host_rdata %s[%0d] expected %h, got %h",
               $time, name, a, exp, host_rdata);
    end
  endtask

  // whole memory so untouched ranges and gradients are covered too
  task automatic check_all();
    for (int a = 0; a < DEPTH; a++) begin
      check_word(optim_pkg::FIELD_W, a, ref_w[a], "w");
      check_word(optim_pkg::FIELD_V, a, ref_v[a], "v");
      check_word(optim_pkg::FIELD_GRAD, a, ref_g[a], "grad");
    end
  endtask

  // ------------------------------
  // one table step
  // ------------------------------
  task automatic run_step(input int i);
    int base;
    int cyc;
    bit seen;
    base = int'(steps[i].sel) * `MAT_WORDS;
    cyc  = 0;
    seen = 1'b0;
    @(posedge clk);
    #10 sel = steps[i].sel;
    // sequencer parks on the new base before run rises
    @(posedge clk);
    #10 run = 1'b1;
    if (steps[i].kind == PASS_FULL) begin
      while (!seen && cyc < int'(steps[i].run_len)) begin
        @(posedge clk);
        #10;
        cyc++;
        seen = done;
      end
      assert (seen) else begin
        other_errors++;
        $display("step %0d: done never rose within %0d cycles", i, steps[i].run_len);
      end
      assert (!seen || (cyc >= `MAT_WORDS + 3 && cyc <= `MAT_WORDS + 4)) else begin
        other_errors++;
        $display("step %0d: done rose after %0d cycles, outside the expected window", i, cyc);
      end
      @(posedge clk);
      #10;
      assert (!seen || done === 1'b1) else begin
        other_errors++;
        $display("step %0d: done fell while run was still high", i);
      end
    end else begin
      repeat (steps[i].run_len) begin
        @(posedge clk);
        #10;
        assert (done === 1'b0) else begin
          other_errors++;
          $display("step %0d: done rose during a cut pass", i);
        end
      end
    end
    run = 1'b0;
    @(negedge clk);
    assert (done === 1'b0) else begin
      other_errors++;
      $display("step %0d: done stayed high after run fell", i);
    end
    // let in-flight writes land
    repeat (DRAIN) @(posedge clk);
    model_update(base, (steps[i].kind == PASS_FULL) ? `MAT_WORDS : int'(steps[i].run_len));
    check_all();
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial begin
    rst_n      = 1'b0;
    run        = 1'b0;
    sel        = optim_pkg::MIX1;
    host_we    = 1'b0;
    host_field = optim_pkg::FIELD_W;
    host_addr  = '0;
    host_wdata = '0;
    for (int a = 0; a < DEPTH; a++) begin
      ref_w[a] = '0;
      ref_v[a] = '0;
      ref_g[a] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #10 rst_n = 1'b1;
    @(negedge clk);
    assert (done === 1'b0) else begin
      other_errors++;
      $display("done was not low after reset");
    end
    check_all();
    load_memories();
    for (int i = 0; i < NUM_STEPS; i++) run_step(i);
    $display("checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    int limit;
    limit = timeout_limit();
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
source/optim_pkg.sv
source/optim_if.sv
source/param_bank.sv
source/optim_sequencer.sv
source/momentum_lane.sv
source/optim_writeback.sv
source/mix_optim_top.sv
tb/tb_mix_optim.sv
